// File: list.f
rtl/xbar_stream_pkg.sv
rtl/xbar_cfg_pkg.sv
rtl/forwarding_cam.sv
rtl/output_arbiter_mux.sv
rtl/stream_crossbar.sv
test/clock_gen.sv
test/crossbar_checker.sv
test/crossbar_tb.sv

// File: rtl/forwarding_cam.sv
//##########################################################################
// Forwarding CAM for one crossbar input
// Looks up the header destination, requests an egress, counts packets
//##########################################################################
`timescale 1ns/1ns

module forwarding_cam #(
   parameter int NUM_OUTPUTS = 2,
   parameter int BASE        = 0
) (
   input  logic                          clk,
   input  logic                          i_rst_n,
   input  logic                          i_clear,
   input  xbar_stream_pkg::stream_beat_t i_beat,
   input  logic                          i_tvalid,
   input  logic                          i_tready,
   input  logic                          i_pkt_present,
   input  logic [7:0]                    i_local_addr,
   input  xbar_cfg_pkg::set_bus_t        i_set,
   input  logic [NUM_OUTPUTS-1:0]        i_forward_ack,
   input  logic [7:0]                    i_rb_out_sel,
   output logic [NUM_OUTPUTS-1:0]        o_forward_valid,
   output logic [31:0]                   o_rb_count
);
   import xbar_stream_pkg::*;
   import xbar_cfg_pkg::*;

   localparam int EGRESS_W = (NUM_OUTPUTS > 1) ? $clog2(NUM_OUTPUTS) : 1;

   cam_state_t          state;
   logic                mid_pkt;        // Inside a packet, beats are not headers
   logic                beat_xfer;
   logic                hdr_seen;
   logic [DST_W-1:0]    dst;
   logic [TABLE_AW-1:0] lookup_addr;
   logic [TABLE_AW-1:0] rd_addr;
   logic [EGRESS_W-1:0] egress;
   logic [EGRESS_W-1:0] route_table [TABLE_DEPTH];
   logic [15:0]         set_offset;
   logic                set_hit;
   logic [31:0]         pkt_count [NUM_OUTPUTS];

   assign beat_xfer = i_tvalid && i_tready;
   assign hdr_seen  = (state == CAM_IDLE) && i_tvalid && i_pkt_present && !mid_pkt;
   assign dst       = i_beat.tdata[DST_W-1:0];

   // Local node uses the low byte in the upper half of the table
   always_comb begin
      if (dst[DST_W-1 -: NODE_W] == i_local_addr)
         lookup_addr = TABLE_AW'(LOCAL_BASE) + TABLE_AW'(dst[NODE_W-1:0]);
      else
         lookup_addr = TABLE_AW'(dst[DST_W-1 -: NODE_W]);
   end

   // Settings window BASE .. BASE+TABLE_DEPTH-1
   assign set_offset = i_set.addr - 16'(BASE);
   assign set_hit    = i_set.stb && (int'(i_set.addr) >= BASE) &&
                       (int'(set_offset) < TABLE_DEPTH);

   always_ff @(posedge clk) begin
      if (set_hit)
         route_table[set_offset[TABLE_AW-1:0]] <= i_set.data[EGRESS_W-1:0];
      if (hdr_seen)
         rd_addr <= lookup_addr;                 // Header sampled in idle
      if (state == CAM_LOOKUP)
         egress <= route_table[rd_addr];         // Ready for the forward state
   end

   // Packet boundary tracking and lookup sequence
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state   <= CAM_IDLE;
         mid_pkt <= 1'b0;
      end else if (i_clear) begin
         state   <= CAM_IDLE;
         mid_pkt <= 1'b0;
      end else begin
         if (beat_xfer)
            mid_pkt <= !i_beat.tlast;
         case (state)
            CAM_IDLE: begin
               if (hdr_seen)
                  state <= CAM_LOOKUP;
            end
            CAM_LOOKUP: begin
               state <= CAM_FORWARD;
            end
            CAM_FORWARD: begin
               if (|(i_forward_ack & o_forward_valid))
                  state <= CAM_IDLE;             // Request drops next cycle
            end
            default: begin
               state <= CAM_IDLE;
            end
         endcase
      end
   end

   // One-hot request toward the egress mux
   always_comb begin
      o_forward_valid = '0;
      if (state == CAM_FORWARD)
         o_forward_valid[egress] = 1'b1;
   end

   // Completed packets per path, bumped by the ack pulse
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int k = 0; k < NUM_OUTPUTS; k++)
            pkt_count[k] <= '0;
      end else if (i_clear) begin
         for (int k = 0; k < NUM_OUTPUTS; k++)
            pkt_count[k] <= '0;
      end else begin
         for (int k = 0; k < NUM_OUTPUTS; k++) begin
            if (i_forward_ack[k])
               pkt_count[k] <= pkt_count[k] + 32'd1;
         end
      end
   end

   // Out of range select reads as zero
   always_comb begin
      o_rb_count = '0;
      for (int k = 0; k < NUM_OUTPUTS; k++) begin
         if (int'(i_rb_out_sel) == k)
            o_rb_count = pkt_count[k];
      end
   end

endmodule

// File: rtl/output_arbiter_mux.sv
//##########################################################################
// Output arbiter and mux for one crossbar egress
// Grants whole packets round-robin and passes the granted beats through
//##########################################################################
`timescale 1ns/1ns

module output_arbiter_mux #(
   parameter int NUM_INPUTS = 2
) (
   input  logic                                           clk,
   input  logic                                           i_rst_n,
   input  logic                                           i_clear,
   input  xbar_stream_pkg::stream_beat_t [NUM_INPUTS-1:0] i_beats,
   input  logic [NUM_INPUTS-1:0]                          i_tvalid,
   input  logic [NUM_INPUTS-1:0]                          i_forward_valid,
   input  logic                                           i_tready,
   output logic [NUM_INPUTS-1:0]                          o_in_tready,
   output logic [NUM_INPUTS-1:0]                          o_forward_ack,
   output xbar_stream_pkg::stream_beat_t                  o_beat,
   output logic                                           o_tvalid
);
   import xbar_stream_pkg::*;

   localparam int IDX_W = (NUM_INPUTS > 1) ? $clog2(NUM_INPUTS) : 1;

   arb_state_t       state;
   logic [IDX_W-1:0] grant_idx;     // Current grant, also the round-robin pointer
   logic [IDX_W-1:0] next_idx;
   logic             next_found;
   logic             pass;
   logic             last_xfer;

   // Search starts one past the last grant
   always_comb begin
      int cand;
      next_found = 1'b0;
      next_idx   = '0;
      cand       = 0;
      for (int off = 1; off <= NUM_INPUTS; off++) begin
         cand = (int'(grant_idx) + off) % NUM_INPUTS;
         if (!next_found && i_forward_valid[cand]) begin
            next_found = 1'b1;
            next_idx   = IDX_W'(cand);
         end
      end
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state     <= ARB_IDLE;
         grant_idx <= IDX_W'(NUM_INPUTS - 1);     // Input 0 wins first
      end else if (i_clear) begin
         state     <= ARB_IDLE;
         grant_idx <= IDX_W'(NUM_INPUTS - 1);
      end else begin
         case (state)
            ARB_IDLE: begin
               if (next_found) begin
                  grant_idx <= next_idx;
                  state     <= ARB_PASS;
               end
            end
            ARB_PASS: begin
               if (last_xfer)
                  state <= ARB_IDLE;              // Output free again
            end
            default: begin
               state <= ARB_IDLE;
            end
         endcase
      end
   end

   assign pass      = (state == ARB_PASS);
   assign o_beat    = i_beats[grant_idx];
   assign o_tvalid  = pass && i_tvalid[grant_idx];
   assign last_xfer = o_tvalid && i_tready && o_beat.tlast;

   // Ready and ack go to the granted input only
   always_comb begin
      o_in_tready   = '0;
      o_forward_ack = '0;
      if (pass) begin
         o_in_tready[grant_idx]   = i_tready;
         o_forward_ack[grant_idx] = last_xfer;   // One pulse per packet
      end
   end

endmodule

// File: rtl/stream_crossbar.sv
//##########################################################################
// Packet stream crossbar, forwarding CAM per input, arbiter-mux per output
//##########################################################################
`timescale 1ns/1ns

module stream_crossbar #(
   parameter int NUM_INPUTS  = 2,
   parameter int NUM_OUTPUTS = 2,
   parameter int BASE        = 0
) (
   input  logic                                            clk,
   input  logic                                            i_rst_n,
   input  logic                                            i_clear,
   input  logic [7:0]                                      i_local_addr,
   input  xbar_stream_pkg::stream_beat_t [NUM_INPUTS-1:0]  i_in_beat,
   input  logic [NUM_INPUTS-1:0]                           i_in_tvalid,
   input  logic [NUM_INPUTS-1:0]                           i_pkt_present,
   output logic [NUM_INPUTS-1:0]                           o_in_tready,
   input  xbar_cfg_pkg::set_bus_t                          i_set,
   output xbar_stream_pkg::stream_beat_t [NUM_OUTPUTS-1:0] o_out_beat,
   output logic [NUM_OUTPUTS-1:0]                          o_out_tvalid,
   input  logic [NUM_OUTPUTS-1:0]                          i_out_tready,
   input  xbar_cfg_pkg::rb_req_t                           i_rb,
   output logic [31:0]                                     o_rb_data
);

   logic [NUM_OUTPUTS-1:0] cam_fwd_valid [NUM_INPUTS];    // Per input, bit per output
   logic [NUM_OUTPUTS-1:0] cam_fwd_ack   [NUM_INPUTS];
   logic [NUM_INPUTS-1:0]  mux_fwd_valid [NUM_OUTPUTS];   // Per output, bit per input
   logic [NUM_INPUTS-1:0]  mux_fwd_ack   [NUM_OUTPUTS];
   logic [NUM_INPUTS-1:0]  mux_ready     [NUM_OUTPUTS];
   logic [31:0]            rb_count      [NUM_INPUTS];
   logic [31:0]            rb_sel;

   for (genvar n = 0; n < NUM_INPUTS; n++) begin : g_cam
      forwarding_cam #(
         .NUM_OUTPUTS (NUM_OUTPUTS),
         .BASE        (BASE)
      ) u_cam (
         .clk             (clk),
         .i_rst_n         (i_rst_n),
         .i_clear         (i_clear),
         .i_beat          (i_in_beat[n]),
         .i_tvalid        (i_in_tvalid[n]),
         .i_tready        (o_in_tready[n]),
         .i_pkt_present   (i_pkt_present[n]),
         .i_local_addr    (i_local_addr),
         .i_set           (i_set),
         .i_forward_ack   (cam_fwd_ack[n]),
         .i_rb_out_sel    (i_rb.out_sel),
         .o_forward_valid (cam_fwd_valid[n]),
         .o_rb_count      (rb_count[n])
      );
   end

   for (genvar m = 0; m < NUM_OUTPUTS; m++) begin : g_mux
      output_arbiter_mux #(
         .NUM_INPUTS (NUM_INPUTS)
      ) u_mux (
         .clk             (clk),
         .i_rst_n         (i_rst_n),
         .i_clear         (i_clear),
         .i_beats         (i_in_beat),
         .i_tvalid        (i_in_tvalid),
         .i_forward_valid (mux_fwd_valid[m]),
         .i_tready        (i_out_tready[m]),
         .o_in_tready     (mux_ready[m]),
         .o_forward_ack   (mux_fwd_ack[m]),
         .o_beat          (o_out_beat[m]),
         .o_tvalid        (o_out_tvalid[m])
      );
   end

   // Transpose the request and ack flags between the two arrays
   for (genvar m = 0; m < NUM_OUTPUTS; m++) begin : g_perm_out
      for (genvar n = 0; n < NUM_INPUTS; n++) begin : g_perm_in
         assign mux_fwd_valid[m][n] = cam_fwd_valid[n][m];
         assign cam_fwd_ack[n][m]   = mux_fwd_ack[m][n];
      end
   end

   // At most one mux grants a given input
   always_comb begin
      o_in_tready = '0;
      for (int m = 0; m < NUM_OUTPUTS; m++)
         o_in_tready = o_in_tready | mux_ready[m];
   end

   always_comb begin
      rb_sel = '0;
      for (int n = 0; n < NUM_INPUTS; n++) begin
         if (int'(i_rb.in_sel) == n)
            rb_sel = rb_count[n];
      end
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n)
         o_rb_data <= '0;
      else if (i_rb.stb)
         o_rb_data <= rb_sel;      // Held until the next strobe
   end

endmodule

// File: rtl/xbar_cfg_pkg.sv
//##########################################################################
// Configuration definitions for the packet crossbar
// Settings bus, readback request, routing table geometry and CAM states
//##########################################################################

package xbar_cfg_pkg;

   // Routing table, remote half first then local half
   localparam int TABLE_DEPTH = 512;
   localparam int TABLE_AW    = $clog2(TABLE_DEPTH);
   localparam int LOCAL_BASE  = TABLE_DEPTH / 2;

   // Write-only settings bus
   typedef struct packed {
      logic        stb;
      logic [15:0] addr;
      logic [31:0] data;
   } set_bus_t;

   // Readback of one path counter
   typedef struct packed {
      logic       stb;
      logic [7:0] in_sel;    // Which input CAM
      logic [7:0] out_sel;   // Which egress counter
   } rb_req_t;

   typedef enum logic [1:0] {
      CAM_IDLE,      // Waiting for a header beat
      CAM_LOOKUP,    // Table read in progress
      CAM_FORWARD    // Request held until acked
   } cam_state_t;

endpackage

// File: rtl/xbar_stream_pkg.sv
//##########################################################################
// Stream definitions for the packet crossbar
// Beat layout, header destination field and arbiter states
//##########################################################################

package xbar_stream_pkg;

   // Beat payload width
   localparam int DATA_W = 64;

   // Destination field in the low bits of the header beat
   localparam int DST_W  = 16;

   // One node address byte, upper byte of DST is the node
   localparam int NODE_W = 8;

   // One beat on a stream port
   typedef struct packed {
      logic [DATA_W-1:0] tdata;
      logic              tlast;   // Final beat of the packet
   } stream_beat_t;

   // Output arbiter states
   typedef enum logic {
      ARB_IDLE,   // Waiting for a request
      ARB_PASS    // Beats flow from the granted input
   } arb_state_t;

endpackage

// File: test/clock_gen.sv
//##########################################################################
// Testbench clock source, 10 ns period
//##########################################################################
`timescale 1ns/1ns

module clock_gen #(
   parameter int HALF_NS = 5
) (
   output logic o_clk
);

   initial begin
      o_clk = 1'b0;
      forever #HALF_NS o_clk = ~o_clk;
   end

endmodule

// File: test/crossbar_checker.sv
//##########################################################################
// Stream protocol and reset assertions bound into the crossbar
//##########################################################################
`timescale 1ns/1ns

module crossbar_checker #(
   parameter int NUM_INPUTS  = 2,
   parameter int NUM_OUTPUTS = 2
) (
   input logic                                            clk,
   input logic                                            i_rst_n,
   input logic                                            i_clear,
   input xbar_stream_pkg::stream_beat_t [NUM_OUTPUTS-1:0] i_out_beat,
   input logic [NUM_OUTPUTS-1:0]                          i_out_tvalid,
   input logic [NUM_OUTPUTS-1:0]                          i_out_tready,
   input logic [NUM_INPUTS-1:0]                           i_in_tready
);

   int fail_count = 0;   // Failed assertions so far

   // Nothing leaves or is accepted while in reset
   a_reset_quiet: assert property (@(posedge clk)
      !i_rst_n |-> (i_out_tvalid == '0) && (i_in_tready == '0))
      else begin
         fail_count++;
         $error("Stream valid or ready active during reset");
      end

   for (genvar m = 0; m < NUM_OUTPUTS; m++) begin : g_out
      // Stalled beat must stay put
      a_hold: assert property (@(posedge clk) disable iff (!i_rst_n || i_clear)
         i_out_tvalid[m] && !i_out_tready[m] |=>
            i_out_tvalid[m] && $stable(i_out_beat[m]))
         else begin
            fail_count++;
            $error("Output %0d changed while stalled", m);
         end
   end

endmodule

bind stream_crossbar crossbar_checker #(
   .NUM_INPUTS  (NUM_INPUTS),
   .NUM_OUTPUTS (NUM_OUTPUTS)
) u_checker (
   .clk          (clk),
   .i_rst_n      (i_rst_n),
   .i_clear      (i_clear),
   .i_out_beat   (o_out_beat),
   .i_out_tvalid (o_out_tvalid),
   .i_out_tready (i_out_tready),
   .i_in_tready  (o_in_tready)
);

// File: test/crossbar_tb.sv
//##########################################################################
// Crossbar testbench that runs the tests file and scoreboards each egress
//##########################################################################
`timescale 1ns/1ns

module crossbar_tb;
   import xbar_stream_pkg::*;
   import xbar_cfg_pkg::*;

   localparam int NI = 2;
   localparam int NO = 2;

   typedef struct packed {
      logic [7:0]  op;
      logic [15:0] a;
      logic [31:0] b;
      logic [15:0] c;
      logic [7:0]  d;
   } rec_t;

   typedef struct packed {
      logic [15:0] dst;
      logic [15:0] len;
      logic [23:0] num;
   } pkt_t;

   logic                         clk;
   logic                         rst_n;
   logic                         clear;
   stream_beat_t [NI-1:0]        in_beat;
   logic [NI-1:0]                in_tvalid;
   logic [NI-1:0]                pkt_present;
   logic [NI-1:0]                in_tready;
   set_bus_t                     set_bus;
   stream_beat_t [NO-1:0]        out_beat;
   logic [NO-1:0]                out_tvalid;
   logic [NO-1:0]                out_tready;
   rb_req_t                      rb;
   logic [31:0]                  rb_data;

   rec_t          recs[$];
   pkt_t          pend_q[NI][$];
   logic [64:0]   exp_q[NI*NO][$];    // Index is out*NI + in
   logic [7:0]    cur_src[NO];
   logic          in_pkt[NO];
   int            errors = 0;
   int            cycles = 0;
   int            limit  = 32'h7fff_ffff;
   logic [23:0]   pkt_num = '0;

   clock_gen u_clk (.o_clk(clk));

   stream_crossbar #(
      .NUM_INPUTS  (NI),
      .NUM_OUTPUTS (NO),
      .BASE        (0)
   ) uut (
      .clk           (clk),
      .i_rst_n       (rst_n),
      .i_clear       (clear),
      .i_local_addr  (8'h5a),
      .i_in_beat     (in_beat),
      .i_in_tvalid   (in_tvalid),
      .i_pkt_present (pkt_present),
      .o_in_tready   (in_tready),
      .i_set         (set_bus),
      .o_out_beat    (out_beat),
      .o_out_tvalid  (out_tvalid),
      .i_out_tready  (out_tready),
      .i_rb          (rb),
      .o_rb_data     (rb_data)
   );

   task automatic check(input string name, input logic [64:0] got, input logic [64:0] exp);
      if (got !== exp) begin
         errors++;
         $display("MISMATCH %s: got %h expected %h", name, got, exp);
      end
   endtask

   // Source, packet number and beat index make each beat unique
   function automatic stream_beat_t make_beat(input int n, input pkt_t p, input int b);
      stream_beat_t s;
      s.tdata = {8'(n), p.num, 16'(b), p.dst};
      s.tlast = (b == int'(p.len) - 1);
      return s;
   endfunction

   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic drive_input(input int n);
      pkt_t p;
      int   b;
      bit   xfer;
      while (pend_q[n].size() > 0) begin
         p = pend_q[n].pop_front();
         repeat ($urandom % 3) tick();
         b = 0;
         pkt_present[n] = 1'b1;
         in_tvalid[n]   = 1'b1;
         in_beat[n]     = make_beat(n, p, 0);
         while (b < int'(p.len)) begin
            @(negedge clk);
            xfer = in_tvalid[n] && in_tready[n];
            tick();
            if (xfer) begin
               b++;
               if (b < int'(p.len))
                  in_beat[n] = make_beat(n, p, b);
            end
         end
         in_tvalid[n]   = 1'b0;
         pkt_present[n] = 1'b0;
      end
   endtask

   function automatic bit scoreboard_empty();
      for (int k = 0; k < NI*NO; k++)
         if (exp_q[k].size() != 0)
            return 1'b0;
      return 1'b1;
   endfunction

   // Send everything queued on both inputs at once
   task automatic flush_packets();
      fork
         drive_input(0);
         drive_input(1);
      join
      while (!scoreboard_empty())
         tick();
   endtask

   // Egress monitor sampling between edges
   always @(negedge clk) begin
      logic [7:0] src;
      for (int m = 0; m < NO; m++) begin
         if (rst_n && out_tvalid[m] && out_tready[m]) begin
            src = out_beat[m].tdata[63:56];
            if (src >= NI) begin
               errors++;
               $display("Output %0d carried a beat from unknown input %0d", m, src);
            end else if (in_pkt[m] && src != cur_src[m]) begin
               errors++;
               $display("Output %0d interleaved packets from two inputs", m);
            end else if (exp_q[m*NI + src].size() == 0) begin
               errors++;
               $display("Output %0d carried an unexpected beat from input %0d", m, src);
            end else begin
               check($sformatf("o_out_beat[%0d]", m), out_beat[m],
                     exp_q[m*NI + src].pop_front());
            end
            in_pkt[m]  = !out_beat[m].tlast;
            cur_src[m] = src;
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (rst_n)
         out_tready <= #1 NO'($urandom);   // Random back-pressure
      if (cycles > limit) begin
         $display("Timeout after %0d cycles, traffic did not drain", cycles);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   initial begin
      int    fd;
      int    beats;
      int    v0;
      int    v1;
      int    v2;
      int    v3;
      string tok;
      string line;
      rec_t  r;
      pkt_t  p;
      void'($urandom(32'h1cfb_f1c8));
      rst_n       = 1'b0;
      clear       = 1'b0;
      in_beat     = '0;
      in_tvalid   = '0;
      pkt_present = '0;
      set_bus     = '0;
      out_tready  = '0;
      rb          = '0;
      for (int m = 0; m < NO; m++) begin
         in_pkt[m]  = 1'b0;
         cur_src[m] = '0;
      end

      fd = $fopen("test/crossbar_tests.txt", "r");
      if (fd == 0) begin
         $display("Could not open the tests file");
         $display("Simulation finished: FAIL");
         $finish;
      end else begin
         beats = 0;
         while ($fscanf(fd, "%s", tok) == 1) begin
            r = '0;
            r.op = tok.getc(0);
            if (tok.getc(0) == "#")
               void'($fgets(line, fd));
            else if (tok == "W" && $fscanf(fd, "%h %h", v0, v1) == 2) begin
               r.a = 16'(v0);
               r.b = v1;
               recs.push_back(r);
            end else if (tok == "P" && $fscanf(fd, "%h %h %h %h", v0, v1, v2, v3) == 4) begin
               r.a = 16'(v0);
               r.b = v1;
               r.c = 16'(v2);
               r.d = 8'(v3);
               beats += v2;
               recs.push_back(r);
            end else if (tok == "R" && $fscanf(fd, "%h %h %h", v0, v1, v2) == 3) begin
               r.a = 16'(v0);
               r.c = 16'(v1);
               r.b = v2;
               recs.push_back(r);
            end else if (tok == "C")
               recs.push_back(r);
            else begin
               errors++;
               $display("Bad line in the tests file at token %s", tok);
            end
         end
         $fclose(fd);
         limit = 30 * beats + 500;

         repeat (8) @(posedge clk);
         #1 rst_n = 1'b1;
         tick();

         foreach (recs[i]) begin
            r = recs[i];
            if (r.op == "P") begin
               p.dst = r.b[15:0];
               p.len = r.c;
               p.num = pkt_num;
               pkt_num++;
               pend_q[r.a].push_back(p);
               for (int b = 0; b < int'(r.c); b++)
                  exp_q[r.d*NI + r.a].push_back(make_beat(r.a, p, b));
            end else begin
               flush_packets();
               if (r.op == "W") begin
                  set_bus = '{stb: 1'b1, addr: r.a, data: r.b};
                  tick();
                  set_bus = '0;
               end else if (r.op == "C") begin
                  clear = 1'b1;
                  tick();
                  clear = 1'b0;
               end else begin
                  rb = '{stb: 1'b1, in_sel: r.a[7:0], out_sel: r.c[7:0]};
                  tick();
                  rb = '0;
                  check($sformatf("o_rb_data[%0d][%0d]", r.a, r.c), 65'(rb_data),
                        65'(r.b));
               end
            end
         end
         flush_packets();
         repeat (4) tick();

         $display("Run complete with %0d errors and %0d assertion failures over %0d packets",
                  errors, uut.u_checker.fail_count, pkt_num);
         if (errors == 0 && uut.u_checker.fail_count == 0)
            $display("Simulation finished: PASS");
         else
            $display("Simulation finished: FAIL");
         $finish;
      end
   end

endmodule

// File: test/crossbar_tests.txt
# W addr data | P input dst length expected_out | R input output count | C
# All numbers in hex, local address is 5a
W 0112 1
W 0115 0
W 0033 0
W 0034 1
P 0 5a12 4 1
P 1 3344 3 0
R 0 1 1
R 1 0 1
P 0 3301 5 0
P 1 3399 2 0
P 0 5a15 1 0
P 1 34ab 6 1
R 0 0 2
R 1 0 2
R 1 1 1
C
R 0 0 0
R 1 0 0
P 0 3400 3 1
P 1 5a12 2 1
R 0 1 1
R 1 1 1
